// ==== hdl/frame_sram.sv ====
`timescale 1ns/10ps

module frame_sram
  import vga_pkg::*;
#(
  parameter int SRAM_WORDS = 64
) (
  input  logic       clk,
  input  logic       reset,

  // simple write port, used while the reader is stopped
  input  logic       wr_en,
  input  sram_addr_t wr_addr,
  input  sram_data_t wr_data,

  // axi-lite read address channel
  input  sram_addr_t ar_addr,
  input  logic       ar_valid,
  output logic       ar_ready,

  // axi-lite read data channel
  output sram_data_t r_data,
  output logic       r_valid,
  input  logic       r_ready
);

  // only the low address bits that cover the array are decoded
  localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

  sram_data_t mem [SRAM_WORDS];
  logic       ar_accept;

  // one read in flight at a time, so stall the address while a response waits
  assign ar_ready  = !r_valid;
  assign ar_accept = ar_valid && ar_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr[IDX_W-1:0]] <= wr_data;
    end
  end

  // registered read, data lands one cycle after the address is taken
  always_ff @(posedge clk) begin
    if (ar_accept) begin
      r_data <= mem[ar_addr[IDX_W-1:0]];
    end
  end

  // response valid rises the cycle after acceptance and holds until taken
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      r_valid <= 1'b0;
    end else begin
      if (ar_accept) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  // upper address bits are dropped, so an out of range read would alias
  a_read_in_range: assert property (@(posedge clk) disable iff (reset)
    ar_accept |-> (ar_addr < SRAM_WORDS));

  // same aliasing concern on the load path
  a_write_in_range: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> (wr_addr < SRAM_WORDS));

endmodule

// ==== hdl/sample_fifo.sv ====
`timescale 1ns/10ps

module sample_fifo
  import vga_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  logic        clk,
  input  logic        reset,

  input  logic        push,
  input  vga_sample_t push_data,

  input  logic        pop,
  output vga_sample_t head,

  output logic        empty,
  output logic        almost_full
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [SAMPLE_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                full;

  // first word fall through, head is valid whenever not empty
  assign head = vga_sample_t'(mem[rd_ptr]);

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(FIFO_DEPTH));
  // two slots of slack cover a read that is already in flight
  assign almost_full = (count >= CNT_W'(FIFO_DEPTH - 2));

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // reader back-pressure has to keep us from overflowing
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> !full);

  // driver only pops what is there
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty);

endmodule

// ==== hdl/sram_pixel_reader.sv ====
`timescale 1ns/10ps

module sram_pixel_reader
  import vga_pkg::*;
#(
  parameter int H_VISIBLE     = 8,
  parameter int H_FRONT_PORCH = 1,
  parameter int H_SYNC_PULSE  = 2,
  parameter int H_WHOLE_LINE  = 12,
  parameter int V_VISIBLE     = 4,
  parameter int V_FRONT_PORCH = 1,
  parameter int V_SYNC_PULSE  = 1,
  parameter int V_WHOLE_FRAME = 7
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,

  // axi-lite read address channel
  output sram_addr_t  ar_addr,
  output logic        ar_valid,
  input  logic        ar_ready,

  // axi-lite read data channel
  input  sram_data_t  r_data,
  input  logic        r_valid,
  output logic        r_ready,

  // fifo back-pressure and sample push
  input  logic        almost_full,
  output logic        push,
  output vga_sample_t sample
);

  localparam int H_SYNC_START = H_VISIBLE + H_FRONT_PORCH;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC_PULSE;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT_PORCH;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC_PULSE;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    READ_WAIT
  } state_t;

  // raster position, row and column together
  typedef struct packed {
    coord_t row;
    coord_t col;
  } pos_t;

  state_t     state;
  state_t     next_state;
  logic       read_start;
  logic       read_accepted;
  logic       read_done;
  pos_t       read_pos;
  pos_t       vga_pos;
  sram_addr_t pixel_addr;
  logic       vga_visible;

  // next raster position, wrapping the column at end of line
  // and the row at end of frame
  function automatic pos_t step_pos(input pos_t pos);
    pos_t nxt;
    nxt = pos;
    if (pos.col == coord_t'(H_WHOLE_LINE - 1)) begin
      nxt.col = '0;
      if (pos.row == coord_t'(V_WHOLE_FRAME - 1)) begin
        nxt.row = '0;
      end else begin
        nxt.row = pos.row + 1'b1;
      end
    end else begin
      nxt.col = pos.col + 1'b1;
    end
    return nxt;
  endfunction

  assign read_accepted = ar_valid && ar_ready;
  assign read_done     = r_valid && r_ready;

  // idle -> read -> read_wait -> idle, so one read every three cycles
  // a new read only starts with room in the fifo
  always_comb begin
    next_state = state;
    read_start = 1'b0;
    case (state)
      IDLE: begin
        if (enable && !almost_full) begin
          read_start = 1'b1;
          next_state = READ;
        end
      end
      READ: begin
        if (read_accepted) begin
          next_state = READ_WAIT;
        end
      end
      READ_WAIT: begin
        // dropping enable lands here, the last response still gets pushed
        if (read_done) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // read side position and word address
  // address runs along visible columns only, so no row multiply is needed
  // blanking columns re-read the next word and the result is dropped
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      read_pos   <= '0;
      pixel_addr <= '0;
    end else begin
      if (read_start) begin
        read_pos <= step_pos(read_pos);
        if (read_pos.col < H_VISIBLE) begin
          pixel_addr <= pixel_addr + 1'b1;
        end
      end
      // back to the top of the buffer during vertical blanking
      if (read_pos.row >= V_VISIBLE) begin
        pixel_addr <= '0;
      end
    end
  end

  // address request
  // r_ready comes up after reset and stays up
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ar_valid <= 1'b0;
      r_ready  <= 1'b0;
    end else begin
      r_ready <= 1'b1;
      if (read_start) begin
        ar_valid <= 1'b1;
      end else if (read_accepted) begin
        ar_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read_start) begin
      ar_addr <= pixel_addr;
    end
  end

  // response side position, one step per returned word
  // lags read_pos by the memory latency
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vga_pos <= '0;
      push    <= 1'b0;
    end else begin
      push <= read_done;
      if (read_done) begin
        vga_pos <= step_pos(vga_pos);
      end
    end
  end

  assign vga_visible = (vga_pos.col < H_VISIBLE) && (vga_pos.row < V_VISIBLE);

  // decode sync and colour for the position that just came back
  always_ff @(posedge clk) begin
    if (read_done) begin
      sample.hsync     <= !((vga_pos.col >= H_SYNC_START) && (vga_pos.col < H_SYNC_END));
      sample.vsync     <= !((vga_pos.row >= V_SYNC_START) && (vga_pos.row < V_SYNC_END));
      // colours forced to black outside the visible window
      sample.rgb.red   <= vga_visible ? colour_t'(r_data[15:12]) : '0;
      sample.rgb.green <= vga_visible ? colour_t'(r_data[11:8]) : '0;
      sample.rgb.blue  <= vga_visible ? colour_t'(r_data[7:4]) : '0;
    end
  end

  // address must hold steady while the sram stalls it
  a_ar_hold: assert property (@(posedge clk) disable iff (reset)
    (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr)));

endmodule

// ==== hdl/vga_driver.sv ====
`timescale 1ns/10ps

module vga_driver
  import vga_pkg::*;
#(
  parameter int PIXEL_DIV = 4
) (
  input  logic        clk,
  input  logic        reset,

  // fifo head side
  input  vga_sample_t head,
  input  logic        empty,
  output logic        pop,

  // vga pins
  output logic        vga_hsync,
  output logic        vga_vsync,
  output colour_t     vga_red,
  output colour_t     vga_green,
  output colour_t     vga_blue,

  output logic        pixel_valid,
  output logic        underflow
);

  localparam int DIV_W = (PIXEL_DIV > 1) ? $clog2(PIXEL_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  logic             started;

  // pixel clock enable, one tick every PIXEL_DIV clocks
  assign tick = (div_cnt == DIV_W'(PIXEL_DIV - 1));
  assign pop  = tick && !empty;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
    end
  end

  // pins update the cycle after the pop
  // between pixels they hold the last sample
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vga_hsync   <= 1'b1;
      vga_vsync   <= 1'b1;
      vga_red     <= '0;
      vga_green   <= '0;
      vga_blue    <= '0;
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= pop;
      if (pop) begin
        vga_hsync <= head.hsync;
        vga_vsync <= head.vsync;
        vga_red   <= head.rgb.red;
        vga_green <= head.rgb.green;
        vga_blue  <= head.rgb.blue;
      end
    end
  end

  // an empty fifo only counts as underflow once the stream is running,
  // ticks before the first sample are just start-up
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      started   <= 1'b0;
      underflow <= 1'b0;
    end else begin
      if (pop) begin
        started <= 1'b1;
      end
      // sticky until reset
      if (tick && empty && started) begin
        underflow <= 1'b1;
      end
    end
  end

endmodule

// ==== hdl/vga_frame_top.sv ====
`timescale 1ns/10ps

module vga_frame_top
  import vga_pkg::*;
#(
  // small raster so a simulated frame stays short
  parameter int H_VISIBLE     = 8,
  parameter int H_FRONT_PORCH = 1,
  parameter int H_SYNC_PULSE  = 2,
  parameter int H_WHOLE_LINE  = 12,
  parameter int V_VISIBLE     = 4,
  parameter int V_FRONT_PORCH = 1,
  parameter int V_SYNC_PULSE  = 1,
  parameter int V_WHOLE_FRAME = 7,
  parameter int FIFO_DEPTH    = 8,
  parameter int PIXEL_DIV     = 4,
  parameter int SRAM_WORDS    = 64
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,

  // frame buffer load port
  input  logic       wr_en,
  input  sram_addr_t wr_addr,
  input  sram_data_t wr_data,

  output logic       vga_hsync,
  output logic       vga_vsync,
  output colour_t    vga_red,
  output colour_t    vga_green,
  output colour_t    vga_blue,
  output logic       pixel_valid,
  output logic       underflow
);

  // reader to sram read channel
  sram_addr_t  ar_addr;
  logic        ar_valid;
  logic        ar_ready;
  sram_data_t  r_data;
  logic        r_valid;
  logic        r_ready;

  // sample path
  logic        push;
  vga_sample_t sample;
  logic        almost_full;
  logic        pop;
  vga_sample_t head;
  logic        empty;

  frame_sram #(
    .SRAM_WORDS(SRAM_WORDS)
  ) u_frame_sram (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .ar_addr (ar_addr),
    .ar_valid(ar_valid),
    .ar_ready(ar_ready),
    .r_data  (r_data),
    .r_valid (r_valid),
    .r_ready (r_ready)
  );

  sram_pixel_reader #(
    .H_VISIBLE    (H_VISIBLE),
    .H_FRONT_PORCH(H_FRONT_PORCH),
    .H_SYNC_PULSE (H_SYNC_PULSE),
    .H_WHOLE_LINE (H_WHOLE_LINE),
    .V_VISIBLE    (V_VISIBLE),
    .V_FRONT_PORCH(V_FRONT_PORCH),
    .V_SYNC_PULSE (V_SYNC_PULSE),
    .V_WHOLE_FRAME(V_WHOLE_FRAME)
  ) u_reader (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .ar_addr    (ar_addr),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r_data     (r_data),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .almost_full(almost_full),
    .push       (push),
    .sample     (sample)
  );

  sample_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_data  (sample),
    .pop        (pop),
    .head       (head),
    .empty      (empty),
    .almost_full(almost_full)
  );

  vga_driver #(
    .PIXEL_DIV(PIXEL_DIV)
  ) u_driver (
    .clk        (clk),
    .reset      (reset),
    .head       (head),
    .empty      (empty),
    .pop        (pop),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_red    (vga_red),
    .vga_green  (vga_green),
    .vga_blue   (vga_blue),
    .pixel_valid(pixel_valid),
    .underflow  (underflow)
  );

endmodule

// ==== hdl/vga_pkg.sv ====
// shared widths and sample formats for the vga scan-out path
package vga_pkg;

  // frame buffer word address
  typedef logic [15:0] sram_addr_t;

  // frame buffer word
  // [15:12] red, [11:8] green, [7:4] blue, [3:0] spare
  typedef logic [15:0] sram_data_t;

  // raster column or row
  typedef logic [9:0] coord_t;

  // one colour channel as it leaves on the pins
  typedef logic [3:0] colour_t;

  typedef struct packed {
    colour_t red;
    colour_t green;
    colour_t blue;
  } rgb_t;

  // one pixel position on the wire
  // sync levels are active low
  typedef struct packed {
    logic hsync;
    logic vsync;
    rgb_t rgb;
  } vga_sample_t;

  // storage width of one fifo entry
  localparam int SAMPLE_W = $bits(vga_sample_t);

endpackage

// ==== src.f ====
hdl/vga_pkg.sv
hdl/frame_sram.sv
hdl/sram_pixel_reader.sv
hdl/sample_fifo.sv
hdl/vga_driver.sv
hdl/vga_frame_top.sv
testbench/vga_frame_tb.sv

// ==== testbench/vga_frame_tb.sv ====
`timescale 1ns/10ps

module vga_frame_tb
  import vga_pkg::*;
();

  // small raster, same values the top level uses
  localparam int H_VISIBLE     = 8;
  localparam int H_FRONT_PORCH = 1;
  localparam int H_SYNC_PULSE  = 2;
  localparam int H_WHOLE_LINE  = 12;
  localparam int V_VISIBLE     = 4;
  localparam int V_FRONT_PORCH = 1;
  localparam int V_SYNC_PULSE  = 1;
  localparam int V_WHOLE_FRAME = 7;
  localparam int FIFO_DEPTH    = 8;
  localparam int PIXEL_DIV     = 4;
  localparam int SRAM_WORDS    = 64;

  // columns and rows where the sync pulses sit in this raster
  localparam int HSYNC_COL_FIRST = 9;
  localparam int HSYNC_COL_LAST  = 10;
  localparam int VSYNC_ROW       = 5;

  localparam int FRAME_POS      = H_WHOLE_LINE * V_WHOLE_FRAME;
  localparam int RUN_FRAMES     = 3;
  localparam int TIMEOUT_CYCLES = RUN_FRAMES * FRAME_POS * PIXEL_DIV * 2;
  // enable drops partway into the third frame
  localparam int PAUSE_AT       = 2 * FRAME_POS + 30;
  localparam int PAUSE_CYCLES   = 40;
  localparam logic [31:0] LFSR_SEED = 32'hbe483177;

  localparam int NUM_TESTS   = 5;
  localparam int T_VISIBLE   = 0;
  localparam int T_BLANK     = 1;
  localparam int T_SYNC      = 2;
  localparam int T_PAUSE     = 3;
  localparam int T_UNDERFLOW = 4;

  typedef struct packed {
    sram_addr_t addr;
    sram_data_t data;
  } load_entry_t;

  // fixed frame buffer words, the rest of the buffer comes from the lfsr
  localparam int LOAD_N = 8;
  localparam load_entry_t LOAD_TABLE [LOAD_N] = '{
    {16'd0,  16'h0000},   // black
    {16'd1,  16'hffff},   // all bits set
    {16'd2,  16'hf000},   // red only
    {16'd3,  16'h0f00},   // green only
    {16'd4,  16'h00f0},   // blue only
    {16'd15, 16'hffff},   // last pixel of row 1
    {16'd24, 16'h0000},   // first pixel of row 3
    {16'd31, 16'h5a30}    // last visible pixel
  };

  logic       clk = 1'b0;
  logic       reset;
  logic       enable;
  logic       wr_en;
  sram_addr_t wr_addr;
  sram_data_t wr_data;
  logic       vga_hsync;
  logic       vga_vsync;
  colour_t    vga_red;
  colour_t    vga_green;
  colour_t    vga_blue;
  logic       pixel_valid;
  logic       underflow;

  // reference copy of the frame buffer
  sram_data_t  mirror [SRAM_WORDS];
  logic [31:0] lfsr_state;

  // reference raster position of the next output sample
  int model_col = 0;
  int model_row = 0;
  int sample_count = 0;
  int cycle_count = 0;
  int total_errors = 0;
  int test_checks [NUM_TESTS];
  int test_errors [NUM_TESTS];
  // samples from the pause onwards also count toward the pause test
  logic paused_once = 1'b0;

  always #20 clk = ~clk;

  vga_frame_top #(
    .H_VISIBLE    (H_VISIBLE),
    .H_FRONT_PORCH(H_FRONT_PORCH),
    .H_SYNC_PULSE (H_SYNC_PULSE),
    .H_WHOLE_LINE (H_WHOLE_LINE),
    .V_VISIBLE    (V_VISIBLE),
    .V_FRONT_PORCH(V_FRONT_PORCH),
    .V_SYNC_PULSE (V_SYNC_PULSE),
    .V_WHOLE_FRAME(V_WHOLE_FRAME),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .PIXEL_DIV    (PIXEL_DIV),
    .SRAM_WORDS   (SRAM_WORDS)
  ) dut (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_red    (vga_red),
    .vga_green  (vga_green),
    .vga_blue   (vga_blue),
    .pixel_valid(pixel_valid),
    .underflow  (underflow)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[14:0], lfsr_state[0]};
    end
  endtask

  function automatic string test_name(input int tid);
    case (tid)
      T_VISIBLE: return "reset state and visible colours";
      T_BLANK:   return "blanking colours";
      T_SYNC:    return "sync timing";
      T_PAUSE:   return "pause and resume";
      default:   return "no underflow while streaming";
    endcase
  endfunction

  task automatic check_value(input int tid, input string name,
                             input logic [15:0] expected, input logic [15:0] actual);
    test_checks[tid]++;
    if (actual !== expected) begin
      test_errors[tid]++;
      total_errors++;
      $display("** Error at %0t ns: %s expected %0h, got %0h (col %0d, row %0d)",
               $time, name, expected, actual, model_col, model_row);
    end
  endtask

  // compare one output sample with the reference position, then step it
  task automatic check_sample();
    logic       visible;
    logic       exp_hsync;
    logic       exp_vsync;
    sram_data_t word;
    int         tid;
    int         errs_before;
    visible   = (model_col < H_VISIBLE) && (model_row < V_VISIBLE);
    exp_hsync = !((model_col == HSYNC_COL_FIRST) || (model_col == HSYNC_COL_LAST));
    exp_vsync = (model_row != VSYNC_ROW);
    // blanking positions are black
    word = '0;
    tid  = T_BLANK;
    if (visible) begin
      word = mirror[model_row * H_VISIBLE + model_col];
      tid  = T_VISIBLE;
    end
    errs_before = total_errors;
    check_value(tid, "vga_red", word[15:12], vga_red);
    check_value(tid, "vga_green", word[11:8], vga_green);
    check_value(tid, "vga_blue", word[7:4], vga_blue);
    check_value(T_SYNC, "vga_hsync", exp_hsync, vga_hsync);
    check_value(T_SYNC, "vga_vsync", exp_vsync, vga_vsync);
    // a skipped or repeated position shows up as a mismatch here
    if (paused_once) begin
      test_checks[T_PAUSE]++;
      if (total_errors != errs_before) begin
        test_errors[T_PAUSE]++;
      end
    end
    if (model_col == H_WHOLE_LINE - 1) begin
      model_col = 0;
      model_row = (model_row == V_WHOLE_FRAME - 1) ? 0 : model_row + 1;
    end else begin
      model_col++;
    end
    sample_count++;
  endtask

  // outputs are registered on the rising edge, so look at them mid cycle
  always @(negedge clk) begin
    if (!reset && pixel_valid) begin
      check_sample();
    end
  end

  // sample_count is stable at the rising edge; return on a falling edge
  task automatic wait_samples(input int n);
    while (sample_count < n) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d samples seen",
               cycle_count, sample_count, RUN_FRAMES * FRAME_POS);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    int         i;
    int         failed_tests;
    int         drop_count;
    int         pause_samples;
    sram_data_t word;
    reset      = 1'b1;
    enable     = 1'b0;
    wr_en      = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    lfsr_state = LFSR_SEED;
    for (i = 0; i < NUM_TESTS; i++) begin
      test_checks[i] = 0;
      test_errors[i] = 0;
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);

    // idle outputs while enable is still low
    check_value(T_VISIBLE, "pixel_valid", 1'b0, pixel_valid);
    check_value(T_VISIBLE, "vga_hsync", 1'b1, vga_hsync);
    check_value(T_VISIBLE, "vga_vsync", 1'b1, vga_vsync);
    check_value(T_VISIBLE, "vga_red", '0, vga_red);
    check_value(T_VISIBLE, "vga_green", '0, vga_green);
    check_value(T_VISIBLE, "vga_blue", '0, vga_blue);

    // lfsr background first, then the fixed table on top
    for (i = 0; i < SRAM_WORDS; i++) begin
      draw_bits(16, word);
      mirror[i] = word;
    end
    for (i = 0; i < LOAD_N; i++) begin
      mirror[LOAD_TABLE[i].addr] = LOAD_TABLE[i].data;
    end
    for (i = 0; i < SRAM_WORDS; i++) begin
      wr_en   = 1'b1;
      wr_addr = sram_addr_t'(i);
      wr_data = mirror[i];
      @(negedge clk);
    end
    wr_en = 1'b0;
    @(negedge clk);

    // two whole frames cover the row and column wrap
    enable = 1'b1;
    wait_samples(2 * FRAME_POS);
    check_value(T_UNDERFLOW, "underflow", 1'b0, underflow);
    wait_samples(PAUSE_AT);
    check_value(T_UNDERFLOW, "underflow", 1'b0, underflow);

    // reader finishes its read in flight, the fifo drains
    enable     = 1'b0;
    paused_once = 1'b1;
    drop_count = sample_count;
    repeat (PAUSE_CYCLES - 1) @(negedge clk);
    // last cycle of the pause, counted on its rising edge
    @(posedge clk);
    pause_samples = sample_count - drop_count;
    @(negedge clk);
    test_checks[T_PAUSE]++;
    // at most a full fifo plus the last read may come out
    if (pause_samples > FIFO_DEPTH + 1) begin
      test_errors[T_PAUSE]++;
      total_errors++;
      $display("pause: %0d samples came out while enable was low, limit is %0d",
               pause_samples, FIFO_DEPTH + 1);
    end
    enable = 1'b1;
    wait_samples(RUN_FRAMES * FRAME_POS);
    $display("underflow after the pause drained the fifo: %0b (reported only)", underflow);

    failed_tests = 0;
    for (i = 0; i < NUM_TESTS; i++) begin
      if (test_errors[i] == 0) begin
        $display("test %0d, %s: pass, %0d checks", i + 1, test_name(i), test_checks[i]);
      end else begin
        failed_tests++;
        $display("test %0d, %s: FAIL, %0d of %0d checks wrong",
                 i + 1, test_name(i), test_errors[i], test_checks[i]);
      end
    end
    $display("%0d of %0d tests passed, %0d samples checked, %0d errors",
             NUM_TESTS - failed_tests, NUM_TESTS, sample_count, total_errors);
    if (failed_tests == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
